//--- verilog/uart_frame_pkg.sv
`default_nettype none

// character format shared by the transmitter, the receiver and the top level
package uart_frame_pkg;

    // which total the parity bit completes over data plus parity
    typedef enum logic {
        PARITY_EVEN = 1'b0, // even number of ones
        PARITY_ODD  = 1'b1  // odd number of ones
    } parity_e;

    // flops between the serial pin and the receiver FSM
    localparam int NUM_SYNC_STAGES = 3;

    // start, parity and stop around the data bits
    localparam int FRAME_OVERHEAD_BITS = 3;

    // level of an idle line and of the stop bit, start bit is its complement
    localparam logic LINE_IDLE = 1'b1;

endpackage

`default_nettype wire

//--- verilog/uart_state_pkg.sv
`default_nettype none

// FSM encodings of both directions, kept side by side
package uart_state_pkg;

    typedef enum logic [2:0] {
        TX_IDLE   = 3'd0, // line idle, ready for a word
        TX_START  = 3'd1,
        TX_DATA   = 3'd2, // data bits, lsb first
        TX_PARITY = 3'd3,
        TX_STOP   = 3'd4
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE   = 3'd0, // waiting for a start edge
        RX_START  = 3'd1, // confirming start at mid bit
        RX_DATA   = 3'd2,
        RX_PARITY = 3'd3,
        RX_STOP   = 3'd4  // result is reported here
    } rx_state_e;

endpackage

`default_nettype wire

//--- verilog/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int DATA_WIDTH = 8,
    parameter int CLOCKS_PER_BIT = 8,
    parameter uart_frame_pkg::parity_e PARITY = uart_frame_pkg::PARITY_EVEN
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  i_enable,
    input  wire [DATA_WIDTH-1:0] i_data,
    output logic                 o_busy,
    output logic                 o_serial_out
);

    // bits queued behind the start bit: data, parity, stop
    localparam int FRAME_W = DATA_WIDTH + uart_frame_pkg::FRAME_OVERHEAD_BITS - 1;
    localparam int CNT_W = (CLOCKS_PER_BIT > 1) ? $clog2(CLOCKS_PER_BIT) : 1;
    localparam int IDX_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLOCKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DATA_WIDTH - 1);
    localparam logic START_LEVEL = ~uart_frame_pkg::LINE_IDLE;

    uart_state_pkg::tx_state_e state;
    logic [CNT_W-1:0]   clk_cnt;     // clocks into the current bit
    logic [IDX_W-1:0]   bit_idx;     // data bit being sent
    logic [FRAME_W-1:0] frame_shift; // next bit to send sits in bit 0
    logic               parity_bit;
    logic               bit_done;
    logic               accept;

    assign accept   = i_enable && (state == uart_state_pkg::TX_IDLE);
    assign bit_done = (clk_cnt == LAST_CNT);
    assign o_busy   = (state != uart_state_pkg::TX_IDLE);

    // parity of the word on i_data, only taken in the accepting cycle
    assign parity_bit = (^i_data) ^ (PARITY == uart_frame_pkg::PARITY_ODD);

    always_ff @(posedge clk) begin
        if (accept) begin
            frame_shift <= {uart_frame_pkg::LINE_IDLE, parity_bit, i_data};
        end else if (o_busy && bit_done) begin
            frame_shift <= {uart_frame_pkg::LINE_IDLE, frame_shift[FRAME_W-1:1]}; // fill with idle
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= uart_state_pkg::TX_IDLE;
            clk_cnt      <= '0;
            bit_idx      <= '0;
            o_serial_out <= uart_frame_pkg::LINE_IDLE;
        end else begin
            case (state)
                uart_state_pkg::TX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (accept) begin
                        state        <= uart_state_pkg::TX_START;
                        o_serial_out <= START_LEVEL; // start bit shows next cycle
                    end
                end
                uart_state_pkg::TX_START: begin
                    if (bit_done) begin
                        state        <= uart_state_pkg::TX_DATA;
                        o_serial_out <= frame_shift[0]; // data bit 0
                    end
                end
                uart_state_pkg::TX_DATA: begin
                    if (bit_done) begin
                        o_serial_out <= frame_shift[0];
                        if (bit_idx == LAST_IDX) begin
                            state <= uart_state_pkg::TX_PARITY; // parity now in bit 0
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                uart_state_pkg::TX_PARITY: begin
                    if (bit_done) begin
                        state        <= uart_state_pkg::TX_STOP;
                        o_serial_out <= frame_shift[0]; // stop bit
                    end
                end
                uart_state_pkg::TX_STOP: begin
                    if (bit_done) begin
                        state        <= uart_state_pkg::TX_IDLE;
                        o_serial_out <= uart_frame_pkg::LINE_IDLE;
                    end
                end
                default: begin
                    state        <= uart_state_pkg::TX_IDLE;
                    o_serial_out <= uart_frame_pkg::LINE_IDLE;
                end
            endcase

            // bit period counter runs for the whole frame
            if (o_busy) begin
                clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int DATA_WIDTH = 8,
    parameter int CLOCKS_PER_BIT = 8,
    parameter uart_frame_pkg::parity_e PARITY = uart_frame_pkg::PARITY_EVEN
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   i_serial_in,
    output logic [DATA_WIDTH-1:0] o_received_data,
    output logic                  o_data_is_valid,
    output logic                  o_rx_error
);

    localparam int SYNC_N = uart_frame_pkg::NUM_SYNC_STAGES;
    // sampled bits after the start bit: data, parity, stop
    localparam int FRAME_W = DATA_WIDTH + uart_frame_pkg::FRAME_OVERHEAD_BITS - 1;
    localparam int CNT_W = (CLOCKS_PER_BIT > 1) ? $clog2(CLOCKS_PER_BIT) : 1;
    localparam int IDX_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLOCKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLOCKS_PER_BIT / 2 - 1);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DATA_WIDTH - 1);
    localparam logic START_LEVEL = ~uart_frame_pkg::LINE_IDLE;

    uart_state_pkg::rx_state_e state;
    logic [SYNC_N-1:0]  sync_q;      // synchronizer chain, oldest in the msb
    logic               rx_line;
    logic [CNT_W-1:0]   clk_cnt;
    logic [IDX_W-1:0]   bit_idx;
    logic [FRAME_W-1:0] frame_shift;
    logic [FRAME_W-1:0] next_frame;  // frame_shift with the current sample shifted in
    logic               bit_done;
    logic               parity_ok;
    logic               stop_ok;

    assign rx_line  = sync_q[SYNC_N-1];
    assign bit_done = (clk_cnt == LAST_CNT);

    // lsb first, so samples enter at the top and move down
    assign next_frame = {rx_line, frame_shift[FRAME_W-1:1]};

    // only meaningful at the stop sample, when next_frame is complete
    assign parity_ok = ((^next_frame[DATA_WIDTH-1:0]) ^
                        (PARITY == uart_frame_pkg::PARITY_ODD)) == next_frame[DATA_WIDTH];
    assign stop_ok   = (next_frame[FRAME_W-1] == uart_frame_pkg::LINE_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q <= {SYNC_N{uart_frame_pkg::LINE_IDLE}};
        end else begin
            sync_q <= {sync_q[SYNC_N-2:0], i_serial_in};
        end
    end

    always_ff @(posedge clk) begin
        if (bit_done && (state != uart_state_pkg::RX_IDLE) &&
            (state != uart_state_pkg::RX_START)) begin
            frame_shift <= next_frame;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= uart_state_pkg::RX_IDLE;
            clk_cnt         <= '0;
            bit_idx         <= '0;
            o_received_data <= '0;
            o_data_is_valid <= 1'b0;
            o_rx_error      <= 1'b0;
        end else begin
            o_data_is_valid <= 1'b0; // both results are single-cycle pulses
            o_rx_error      <= 1'b0;
            case (state)
                uart_state_pkg::RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (rx_line == START_LEVEL) begin
                        state <= uart_state_pkg::RX_START; // falling edge seen
                    end
                end
                uart_state_pkg::RX_START: begin
                    if (clk_cnt == HALF_CNT) begin
                        clk_cnt <= '0; // later samples land mid bit
                        if (rx_line == START_LEVEL) begin
                            state <= uart_state_pkg::RX_DATA;
                        end else begin
                            state <= uart_state_pkg::RX_IDLE; // glitch, not a start bit
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_state_pkg::RX_DATA: begin
                    if (bit_done) begin
                        clk_cnt <= '0;
                        if (bit_idx == LAST_IDX) begin
                            state <= uart_state_pkg::RX_PARITY;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_state_pkg::RX_PARITY: begin
                    if (bit_done) begin
                        clk_cnt <= '0;
                        state   <= uart_state_pkg::RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                uart_state_pkg::RX_STOP: begin
                    if (bit_done) begin
                        clk_cnt <= '0;
                        state   <= uart_state_pkg::RX_IDLE;
                        // a bad frame leaves the last good word in place
                        if (parity_ok && stop_ok) begin
                            o_received_data <= next_frame[DATA_WIDTH-1:0];
                            o_data_is_valid <= 1'b1;
                        end else begin
                            o_rx_error <= 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= uart_state_pkg::RX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_loopback.sv
`timescale 1ns/1ps
`default_nettype none

module uart_loopback #(
    parameter int DATA_WIDTH = 8,
    parameter int CLOCKS_PER_BIT = 8, // even, at least 4
    parameter uart_frame_pkg::parity_e PARITY = uart_frame_pkg::PARITY_EVEN
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   i_enable,
    input  wire  [DATA_WIDTH-1:0] i_data,
    input  wire                   i_loopback,  // 1 feeds the receiver from the transmitter
    input  wire                   i_serial_in, // external serial pin
    output wire                   o_busy,
    output wire                   o_serial_out,
    output wire  [DATA_WIDTH-1:0] o_received_data,
    output wire                   o_data_is_valid,
    output wire                   o_rx_error
);

    wire tx_line;
    wire rx_line;

    assign o_serial_out = tx_line;
    assign rx_line      = i_loopback ? tx_line : i_serial_in;

    uart_tx #(
        .DATA_WIDTH    (DATA_WIDTH),
        .CLOCKS_PER_BIT(CLOCKS_PER_BIT),
        .PARITY        (PARITY)
    ) uart_tx_i (
        .clk         (clk),
        .reset       (reset),
        .i_enable    (i_enable),
        .i_data      (i_data),
        .o_busy      (o_busy),
        .o_serial_out(tx_line)
    );

    uart_rx #(
        .DATA_WIDTH    (DATA_WIDTH),
        .CLOCKS_PER_BIT(CLOCKS_PER_BIT),
        .PARITY        (PARITY)
    ) uart_rx_i (
        .clk            (clk),
        .reset          (reset),
        .i_serial_in    (rx_line),
        .o_received_data(o_received_data),
        .o_data_is_valid(o_data_is_valid),
        .o_rx_error     (o_rx_error)
    );

endmodule

`default_nettype wire

//--- verification/uart_loopback_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module uart_loopback_asserts (
    input wire       clk,
    input wire       reset,
    input wire       i_loopback,
    input wire       o_busy,
    input wire       o_serial_out,
    input wire       o_data_is_valid,
    input wire       o_rx_error,
    input wire [2:0] rx_state     // receiver FSM state
);

    // a frame ends either clean or in error, never both
    property single_result;
        @(posedge clk) disable iff (reset)
            !(o_data_is_valid && o_rx_error);
    endproperty

    // the line rests at the idle level between frames
    property idle_line_when_free;
        @(posedge clk) disable iff (reset)
            !o_busy |-> (o_serial_out == uart_frame_pkg::LINE_IDLE);
    endproperty

    // in loopback the receiver is done by the time the transmitter frees up
    property rx_idle_when_free;
        @(posedge clk) disable iff (reset)
            (!o_busy && i_loopback) |-> (rx_state == uart_state_pkg::RX_IDLE);
    endproperty

    single_result_a: assert property (single_result)
        else $error("o_data_is_valid and o_rx_error are high in the same cycle");

    idle_line_a: assert property (idle_line_when_free)
        else $error("o_serial_out left the idle level while o_busy is low");

    rx_idle_a: assert property (rx_idle_when_free)
        else $error("receiver not idle while the looped-back transmitter is free");

endmodule

bind uart_loopback uart_loopback_asserts uart_loopback_asserts_i (
    .clk            (clk),
    .reset          (reset),
    .i_loopback     (i_loopback),
    .o_busy         (o_busy),
    .o_serial_out   (o_serial_out),
    .o_data_is_valid(o_data_is_valid),
    .o_rx_error     (o_rx_error),
    .rx_state       (uart_rx_i.state)
);

`default_nettype wire

//--- verification/uart_loopback_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_loopback_tb;

    localparam int DATA_WIDTH = 8;
    localparam int CLOCKS_PER_BIT = 8;
    localparam uart_frame_pkg::parity_e PARITY = uart_frame_pkg::PARITY_ODD;
    localparam int FRAME_BITS = DATA_WIDTH + uart_frame_pkg::FRAME_OVERHEAD_BITS;
    localparam int FRAME_CYCLES = FRAME_BITS * CLOCKS_PER_BIT;
    localparam int NUM_RANDOM = 40;
    localparam int NUM_FRAMES = NUM_RANDOM + 3 + 4 + 2; // loopback, back-pressure, external, slack
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CYCLES * 2 + 500;
    localparam real CLK_PERIOD = 4.0;
    // start bit on the receiver input to result pulse, within one cycle
    localparam int RX_LATENCY = (DATA_WIDTH + 2) * CLOCKS_PER_BIT + CLOCKS_PER_BIT / 2
                                + uart_frame_pkg::NUM_SYNC_STAGES;

    logic                  clk;
    logic                  reset;
    logic                  i_enable;
    logic [DATA_WIDTH-1:0] i_data;
    logic                  i_loopback;
    logic                  i_serial_in;
    wire                   o_busy;
    wire                   o_serial_out;
    wire  [DATA_WIDTH-1:0] o_received_data;
    wire                   o_data_is_valid;
    wire                   o_rx_error;

    bit                    exp_error_q[$]; // outstanding receive results, oldest first
    logic [DATA_WIDTH-1:0] exp_data_q[$];
    int                    exp_start_q[$];
    int                    cycle_count;
    logic [DATA_WIDTH-1:0] last_good;      // word o_received_data should hold

    uart_loopback #(
        .DATA_WIDTH    (DATA_WIDTH),
        .CLOCKS_PER_BIT(CLOCKS_PER_BIT),
        .PARITY        (PARITY)
    ) uart_loopback_i (
        .clk            (clk),
        .reset          (reset),
        .i_enable       (i_enable),
        .i_data         (i_data),
        .i_loopback     (i_loopback),
        .i_serial_in    (i_serial_in),
        .o_busy         (o_busy),
        .o_serial_out   (o_serial_out),
        .o_received_data(o_received_data),
        .o_data_is_valid(o_data_is_valid),
        .o_rx_error     (o_rx_error)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // serial bits of one character, bit 0 goes on the line first
    function automatic logic [FRAME_BITS-1:0] expected_frame(
        input logic [DATA_WIDTH-1:0] word,
        input uart_frame_pkg::parity_e mode
    );
        logic [FRAME_BITS-1:0] bits;
        int                    ones;
        ones = 0;
        bits[0] = 1'b0; // start
        for (int i = 0; i < DATA_WIDTH; i++) begin
            bits[i + 1] = word[i];
            ones += word[i];
        end
        // parity bit tops up the count of ones to even or odd
        if (mode == uart_frame_pkg::PARITY_ODD) begin
            bits[DATA_WIDTH + 1] = ((ones % 2) == 0);
        end else begin
            bits[DATA_WIDTH + 1] = ((ones % 2) == 1);
        end
        bits[DATA_WIDTH + 2] = 1'b1; // stop
        return bits;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
            fail_run("value mismatch");
        end
    endtask

    // step to just after the next rising edge, where outputs have settled
    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic expect_result(input bit is_error, input logic [DATA_WIDTH-1:0] data);
        exp_error_q.push_back(is_error);
        exp_data_q.push_back(data);
        exp_start_q.push_back(cycle_count); // start bit goes out now
        if (!is_error) begin
            last_good = data;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_error_q.size() != 0 && waited < 2 * FRAME_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (exp_error_q.size() != 0) begin
            fail_run("an expected receive result never arrived");
        end
    endtask

    task automatic send_word(input logic [DATA_WIDTH-1:0] word, input bit with_noise);
        logic [FRAME_BITS-1:0] bits;
        int                    busy_cycles;
        bits = expected_frame(word, PARITY);
        busy_cycles = 0;
        i_enable = 1'b1;
        i_data = word;
        next_cycle();
        i_enable = 1'b0;
        i_data = ~word; // later requests carry different data
        check_value("start bit after accept", 0, o_serial_out);
        expect_result(1'b0, word);
        for (int b = 0; b < FRAME_BITS; b++) begin
            for (int c = 0; c < CLOCKS_PER_BIT; c++) begin
                if (c == CLOCKS_PER_BIT / 2) begin
                    check_value($sformatf("tx bit %0d", b), bits[b], o_serial_out);
                end
                if (o_busy) begin
                    busy_cycles++;
                end
                i_enable = with_noise && (c == 1) && (b % 3 == 1);
                next_cycle();
            end
        end
        i_enable = 1'b0;
        check_value("busy length", FRAME_CYCLES, busy_cycles);
        check_value("busy after frame", 0, o_busy);
    endtask

    task automatic drive_serial(input logic [FRAME_BITS-1:0] bits);
        for (int b = 0; b < FRAME_BITS; b++) begin
            i_serial_in = bits[b];
            repeat (CLOCKS_PER_BIT) next_cycle();
        end
        i_serial_in = 1'b1;
        repeat (2 * CLOCKS_PER_BIT) next_cycle(); // idle gap
    endtask

    always @(negedge clk) begin : compare_results
        bit                    exp_error;
        logic [DATA_WIDTH-1:0] exp_data;
        int                    latency;
        if (!reset && (o_data_is_valid || o_rx_error)) begin
            if (exp_error_q.size() == 0) begin
                fail_run("receive pulse seen with no frame outstanding");
            end else begin
                exp_error = exp_error_q.pop_front();
                exp_data = exp_data_q.pop_front();
                latency = cycle_count - exp_start_q.pop_front();
                check_value("rx error pulse", exp_error, o_rx_error);
                check_value("rx valid pulse", !exp_error, o_data_is_valid);
                check_value("rx data", exp_data, o_received_data);
                if (latency < RX_LATENCY - 1 || latency > RX_LATENCY + 1) begin
                    check_value("rx latency", RX_LATENCY, latency);
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("simulation timed out before all tests finished");
    end

    initial begin : stimulus
        int unsigned           seed_init;
        logic [DATA_WIDTH-1:0] word;
        logic [FRAME_BITS-1:0] bits;
        seed_init = $urandom(32'h9ae2);
        clk = 1'b0;
        reset = 1'b1;
        i_enable = 1'b0;
        i_data = '0;
        i_loopback = 1'b1;
        i_serial_in = 1'b1;
        cycle_count = 0;
        last_good = '0;
        repeat (8) @(posedge clk);
        #0.5;
        reset = 1'b0;

        repeat (16) begin // quiet link until the first request
            check_value("idle busy", 0, o_busy);
            check_value("idle valid", 0, o_data_is_valid);
            check_value("idle error", 0, o_rx_error);
            check_value("idle line", 1, o_serial_out);
            next_cycle();
        end
        check_value("data after reset", 0, o_received_data);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            word = DATA_WIDTH'($urandom);
            send_word(word, 1'b0);
            wait_drained();
        end

        for (int n = 0; n < 3; n++) begin // requests while busy must be dropped
            word = DATA_WIDTH'($urandom);
            send_word(word, 1'b1);
            wait_drained();
        end

        i_loopback = 1'b0;
        word = DATA_WIDTH'($urandom);
        expect_result(1'b0, word);
        drive_serial(expected_frame(word, PARITY));
        wait_drained();

        bits = expected_frame(DATA_WIDTH'($urandom), PARITY);
        bits[DATA_WIDTH + 1] = ~bits[DATA_WIDTH + 1]; // wrong parity
        expect_result(1'b1, last_good);
        drive_serial(bits);
        wait_drained();

        bits = expected_frame(DATA_WIDTH'($urandom), PARITY);
        bits[FRAME_BITS - 1] = 1'b0; // framing error
        expect_result(1'b1, last_good);
        drive_serial(bits);
        wait_drained();

        // short low pulse, rejected at the mid start check
        i_serial_in = 1'b0;
        repeat (CLOCKS_PER_BIT / 2 - 1) next_cycle();
        i_serial_in = 1'b1;
        repeat (FRAME_CYCLES) next_cycle();

        if (exp_error_q.size() != 0) begin
            fail_run("receive results still outstanding at the end");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/uart_frame_pkg.sv
verilog/uart_state_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_loopback.sv
verification/uart_loopback_asserts.sv
verification/uart_loopback_tb.sv
